//--- build.f
rtl/mpmc_pkg.sv
rtl/mpmc_ch_if.sv
rtl/mpmc_ch_decode.sv
rtl/mpmc_ch_prioritize.sv
rtl/mpmc_mem_exec.sv
rtl/mpmc_result.sv
rtl/mpmc_top.sv
tests/mpmc_clkgen.sv
tests/mpmc_props.sv
tests/mpmc_tb.sv

//--- rtl/mpmc_ch_decode.sv
`timescale 1ns/1ps
`default_nettype none

// =====================================================================
// Wishbone classic slave front end of one channel
// =====================================================================

module mpmc_ch_decode (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        cyc,
	input  wire logic                        stb,
	input  wire logic                        we,
	input  wire logic [mpmc_pkg::ADR_W-1:0]  adr,
	input  wire logic [mpmc_pkg::DATA_W-1:0] dat_w,
	input  wire logic [mpmc_pkg::SEL_W-1:0]  sel,
	output logic                             ack,
	output logic [mpmc_pkg::DATA_W-1:0]      dat_r,
	input  wire logic                        inv_valid,
	input  wire logic [mpmc_pkg::WADR_W-1:0] inv_wadr,
	mpmc_ch_if.chan                          req
);

	// Latched request, held until the memory stage reports done
	logic                         cs_r;
	logic                         we_r;
	logic [mpmc_pkg::WADR_W-1:0]  wadr_r;
	logic [mpmc_pkg::DATA_W-1:0]  wdat_r;
	logic [mpmc_pkg::SEL_W-1:0]   sel_r;

	// One-word read buffer
	logic                         buf_valid;
	logic [mpmc_pkg::WADR_W-1:0]  buf_tag;
	logic [mpmc_pkg::DATA_W-1:0]  buf_data;

	logic [mpmc_pkg::WADR_W-1:0]  adr_w;
	logic                         inv_here;
	logic                         rd_hit;
	logic                         start;
	logic                         fin;

	// Word address of the incoming cycle
	assign adr_w = adr[mpmc_pkg::WADR_W+1:2];

	// An invalidation arriving this cycle for the same word must not be
	// answered from the buffer, the buffer would hand out the old value
	assign inv_here = inv_valid && (inv_wadr == adr_w);
	assign rd_hit   = buf_valid && (buf_tag == adr_w) && !inv_here;

	// A new cycle is taken only when nothing is pending and the previous
	// ack has gone, since stb is still high during the ack cycle
	assign start = cyc && stb && !cs_r && !ack;
	assign fin   = cs_r && req.done;

	// ================================================================
	// Control state
	// ================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			cs_r      <= 1'b0;
			ack       <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			ack <= 1'b0;
			if (start) begin
				// Reads that hit are answered here, all else goes to arbitration
				if (!we && rd_hit)
					ack <= 1'b1;
				else
					cs_r <= 1'b1;
			end
			if (fin) begin
				cs_r <= 1'b0;
				ack  <= 1'b1;
			end
			// Drop the buffer when any channel writes its word
			if (inv_valid && (inv_wadr == buf_tag))
				buf_valid <= 1'b0;
			// Refill on our own read completion
			if (fin && !we_r)
				buf_valid <= 1'b1;
		end
	end

	// ================================================================
	// Payload registers
	// ================================================================

	always_ff @(posedge clk) begin
		if (start) begin
			we_r   <= we;
			wadr_r <= adr_w;
			wdat_r <= dat_w;
			sel_r  <= sel;
		end
		if (start && !we && rd_hit)
			dat_r <= buf_data;
		if (fin && !we_r) begin
			dat_r    <= req.rdat;
			buf_tag  <= wadr_r;
			buf_data <= req.rdat;
		end
	end

	// Request toward the arbiter
	assign req.cs     = cs_r;
	assign req.we     = we_r;
	assign req.wadr   = wadr_r;
	assign req.wdat   = wdat_r;
	assign req.sel    = sel_r;
	assign req.taghit = buf_valid && (buf_tag == wadr_r);

endmodule

`default_nettype wire

//--- rtl/mpmc_ch_if.sv
`timescale 1ns/1ps
`default_nettype none

// =====================================================================
// Request and completion bundle of one channel
// =====================================================================

interface mpmc_ch_if;

	// Request side, owned by the channel front end
	// cs stays high with stable fields until done has been seen
	logic                         cs;
	logic                         we;
	logic [mpmc_pkg::WADR_W-1:0]  wadr;
	logic [mpmc_pkg::DATA_W-1:0]  wdat;
	logic [mpmc_pkg::SEL_W-1:0]   sel;

	// High when the one-word read buffer already holds wadr
	logic                         taghit;

	// Completion side, a one cycle pulse with the read word beside it
	logic                         done;
	logic [mpmc_pkg::DATA_W-1:0]  rdat;

	// Channel front end drives the request and waits for completion
	modport chan (
		output cs, we, wadr, wdat, sel, taghit,
		input  done, rdat
	);

	// Arbitration and memory access only look at the request
	modport exec (
		input cs, we, wadr, wdat, sel, taghit
	);

	// Result stage hands back the completion
	modport res (
		output done, rdat
	);

endinterface

`default_nettype wire

//--- rtl/mpmc_ch_prioritize.sv
`timescale 1ns/1ps
`default_nettype none

// =====================================================================
// Channel selection for the shared memory
// =====================================================================

module mpmc_ch_prioritize (
	input  wire logic    clk,
	input  wire logic    reset,
	input  wire logic    elevate,
	mpmc_ch_if.exec      chans [mpmc_pkg::NUM_CH],
	output mpmc_pkg::ch_t ch
);

	// Pending writes and pending read misses per channel
	logic [mpmc_pkg::NUM_CH-1:0] wr_req;
	logic [mpmc_pkg::NUM_CH-1:0] rd_req;
	mpmc_pkg::ch_t               ch_nxt;

	for (genvar i = 0; i < mpmc_pkg::NUM_CH; i++) begin : g_req
		assign wr_req[i] = chans[i].cs && chans[i].we;
		// A read competes only when its buffer does not already hold the word
		assign rd_req[i] = chans[i].cs && !chans[i].we && !chans[i].taghit;
	end

	// ================================================================
	// Priority orders
	// ================================================================

	// Each loop lets the later match overwrite the earlier one, so the
	// last assignment in source order is the highest priority
	always_comb begin
		ch_nxt = mpmc_pkg::CH_NONE;
		if (elevate) begin
			// Reversed order, writes 7 down to 0 then misses 7 down to 0
			for (int i = 0; i < mpmc_pkg::NUM_CH; i++) begin
				if (rd_req[i])
					ch_nxt = mpmc_pkg::ch_t'(i);
			end
			for (int i = 0; i < mpmc_pkg::NUM_CH; i++) begin
				if (wr_req[i])
					ch_nxt = mpmc_pkg::ch_t'(i);
			end
		end else begin
			// Misses of channels 1 to 7, lowest first
			for (int i = mpmc_pkg::NUM_CH - 1; i > 0; i--) begin
				if (rd_req[i])
					ch_nxt = mpmc_pkg::ch_t'(i);
			end
			// Writes of channels 1 to 7 beat every miss
			for (int i = mpmc_pkg::NUM_CH - 1; i > 0; i--) begin
				if (wr_req[i])
					ch_nxt = mpmc_pkg::ch_t'(i);
			end
			// Channel 0 goes first whether it writes or misses
			if (wr_req[0] || rd_req[0])
				ch_nxt = mpmc_pkg::ch_t'(0);
		end
	end

	// Selection is registered, one cycle behind the requests
	always_ff @(posedge clk) begin
		if (reset)
			ch <= mpmc_pkg::CH_NONE;
		else
			ch <= ch_nxt;
	end

endmodule

`default_nettype wire

//--- rtl/mpmc_mem_exec.sv
`timescale 1ns/1ps
`default_nettype none

// =====================================================================
// Grant sequencer and shared memory array
// =====================================================================

module mpmc_mem_exec (
	input  wire logic                    clk,
	input  wire logic                    reset,
	mpmc_ch_if.exec                      chans [mpmc_pkg::NUM_CH],
	output logic                         acc_done,
	output mpmc_pkg::ch_t                acc_ch,
	output logic                         acc_we,
	output logic [mpmc_pkg::WADR_W-1:0]  acc_wadr,
	output logic [mpmc_pkg::DATA_W-1:0]  acc_rdat
);

	typedef enum logic [1:0] {S_IDLE, S_ACCESS, S_RECOVER} state_t;

	state_t                              state;
	logic                                rec_first;
	logic                                elevate;
	logic [$clog2(mpmc_pkg::ELEVATE_EVERY)-1:0] grant_cnt;
	mpmc_pkg::ch_t                       ch;
	logic [$clog2(mpmc_pkg::NUM_CH)-1:0] gnt_idx;
	logic                                grant;
	logic [mpmc_pkg::DATA_W-1:0]         acc_wdat;
	logic [mpmc_pkg::SEL_W-1:0]          acc_sel;
	logic [mpmc_pkg::DATA_W-1:0]         mem [mpmc_pkg::MEM_WORDS];

	// Flattened request fields so the granted one can be picked by index
	logic                                we_v   [mpmc_pkg::NUM_CH];
	logic [mpmc_pkg::WADR_W-1:0]         wadr_v [mpmc_pkg::NUM_CH];
	logic [mpmc_pkg::DATA_W-1:0]         wdat_v [mpmc_pkg::NUM_CH];
	logic [mpmc_pkg::SEL_W-1:0]          sel_v  [mpmc_pkg::NUM_CH];

	for (genvar i = 0; i < mpmc_pkg::NUM_CH; i++) begin : g_flat
		assign we_v[i]   = chans[i].we;
		assign wadr_v[i] = chans[i].wadr;
		assign wdat_v[i] = chans[i].wdat;
		assign sel_v[i]  = chans[i].sel;
	end

	mpmc_ch_prioritize u_prio (
		.clk     (clk),
		.reset   (reset),
		.elevate (elevate),
		.chans   (chans),
		.ch      (ch)
	);

	assign gnt_idx = ch[$clog2(mpmc_pkg::NUM_CH)-1:0];
	assign grant   = (state == S_IDLE) && (ch != mpmc_pkg::CH_NONE);

	// ================================================================
	// Sequencer and elevate counter
	// ================================================================

	// Two recover cycles let done reach the channel, its cs drop, and the
	// registered selection catch up before the next grant is taken
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= S_IDLE;
			rec_first <= 1'b0;
			grant_cnt <= '0;
			elevate   <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (grant) begin
					state   <= S_ACCESS;
					elevate <= 32'(grant_cnt) == mpmc_pkg::ELEVATE_EVERY - 1;
					if (32'(grant_cnt) == mpmc_pkg::ELEVATE_EVERY - 1)
						grant_cnt <= '0;
					else
						grant_cnt <= grant_cnt + 1'b1;
				end
				S_ACCESS: begin
					state     <= S_RECOVER;
					rec_first <= 1'b1;
				end
				default: begin
					rec_first <= 1'b0;
					if (!rec_first)
						state <= S_IDLE;
				end
			endcase
		end
	end

	// Latch the granted request
	always_ff @(posedge clk) begin
		if (grant) begin
			acc_ch   <= ch;
			acc_we   <= we_v[gnt_idx];
			acc_wadr <= wadr_v[gnt_idx];
			acc_wdat <= wdat_v[gnt_idx];
			acc_sel  <= sel_v[gnt_idx];
		end
	end

	// Byte selected write at the end of the access cycle
	always_ff @(posedge clk) begin
		if ((state == S_ACCESS) && acc_we) begin
			for (int b = 0; b < mpmc_pkg::SEL_W; b++) begin
				if (acc_sel[b])
					mem[acc_wadr][8*b +: 8] <= acc_wdat[8*b +: 8];
			end
		end
	end

	// Read word and completion are presented during the access cycle
	assign acc_rdat = mem[acc_wadr];
	assign acc_done = state == S_ACCESS;

endmodule

`default_nettype wire

//--- rtl/mpmc_pkg.sv
`default_nettype none

// =====================================================================
// Sizes shared by the eight-channel memory controller
// =====================================================================

package mpmc_pkg;

	// Channel count and the width of a channel code
	localparam int NUM_CH = 8;
	localparam int CH_BITS = 4;

	// A channel code is wide enough to hold every channel plus the idle code
	typedef logic [CH_BITS-1:0] ch_t;

	// Code placed on the selection when no channel is requesting
	localparam ch_t CH_NONE = 4'd15;

	// Wishbone data, byte address and byte select widths
	localparam int DATA_W = 32;
	localparam int ADR_W = 32;
	localparam int SEL_W = 4;

	// Shared memory depth and its word address width
	// The word address is taken from byte address bits 9 down to 2
	localparam int MEM_WORDS = 256;
	localparam int WADR_W = 8;

	// After this many grants the next arbitration runs in reversed order
	// This keeps high numbered channels from starving under load
	localparam int ELEVATE_EVERY = 8;

endpackage

`default_nettype wire

//--- rtl/mpmc_result.sv
`timescale 1ns/1ps
`default_nettype none

// =====================================================================
// Completion return and write invalidation
// =====================================================================

module mpmc_result (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        acc_done,
	input  wire mpmc_pkg::ch_t               acc_ch,
	input  wire logic                        acc_we,
	input  wire logic [mpmc_pkg::WADR_W-1:0] acc_wadr,
	input  wire logic [mpmc_pkg::DATA_W-1:0] acc_rdat,
	mpmc_ch_if.res                           chans [mpmc_pkg::NUM_CH],
	output logic                             inv_valid,
	output logic [mpmc_pkg::WADR_W-1:0]      inv_wadr
);

	// One done bit per channel, only the granted one ever pulses
	logic [mpmc_pkg::NUM_CH-1:0]  done_r;

	// Read word is common to all channels, done picks who takes it
	logic [mpmc_pkg::DATA_W-1:0]  rdat_r;

	// ================================================================
	// Per channel completion
	// ================================================================

	for (genvar i = 0; i < mpmc_pkg::NUM_CH; i++) begin : g_done
		always_ff @(posedge clk) begin
			if (reset)
				done_r[i] <= 1'b0;
			else
				done_r[i] <= acc_done && (acc_ch == mpmc_pkg::ch_t'(i));
		end

		assign chans[i].done = done_r[i];
		assign chans[i].rdat = rdat_r;
	end

	always_ff @(posedge clk) begin
		rdat_r <= acc_rdat;
	end

	// ================================================================
	// Invalidation broadcast
	// ================================================================

	// A finished write pulses the word address toward every read buffer
	// in the same cycle the writer sees done
	always_ff @(posedge clk) begin
		if (reset)
			inv_valid <= 1'b0;
		else
			inv_valid <= acc_done && acc_we;
	end

	always_ff @(posedge clk) begin
		if (acc_done)
			inv_wadr <= acc_wadr;
	end

endmodule

`default_nettype wire

//--- rtl/mpmc_top.sv
`timescale 1ns/1ps
`default_nettype none

// =====================================================================
// Eight-channel memory controller with Wishbone classic ports
// =====================================================================

module mpmc_top (
	input  wire logic                                              clk,
	input  wire logic                                              reset,
	input  wire logic [mpmc_pkg::NUM_CH-1:0]                       cyc,
	input  wire logic [mpmc_pkg::NUM_CH-1:0]                       stb,
	input  wire logic [mpmc_pkg::NUM_CH-1:0]                       we,
	input  wire logic [mpmc_pkg::NUM_CH-1:0][mpmc_pkg::ADR_W-1:0]  adr,
	input  wire logic [mpmc_pkg::NUM_CH-1:0][mpmc_pkg::DATA_W-1:0] dat_w,
	input  wire logic [mpmc_pkg::NUM_CH-1:0][mpmc_pkg::SEL_W-1:0]  sel,
	output logic [mpmc_pkg::NUM_CH-1:0]                            ack,
	output logic [mpmc_pkg::NUM_CH-1:0][mpmc_pkg::DATA_W-1:0]      dat_r
);

	// Access stage to result stage
	logic                         acc_done;
	mpmc_pkg::ch_t                acc_ch;
	logic                         acc_we;
	logic [mpmc_pkg::WADR_W-1:0]  acc_wadr;
	logic [mpmc_pkg::DATA_W-1:0]  acc_rdat;

	// Result stage back to every read buffer
	logic                         inv_valid;
	logic [mpmc_pkg::WADR_W-1:0]  inv_wadr;

	mpmc_ch_if ch_if [mpmc_pkg::NUM_CH] ();

	// One front end per channel
	for (genvar i = 0; i < mpmc_pkg::NUM_CH; i++) begin : g_ch
		mpmc_ch_decode u_decode (
			.clk       (clk),
			.reset     (reset),
			.cyc       (cyc[i]),
			.stb       (stb[i]),
			.we        (we[i]),
			.adr       (adr[i]),
			.dat_w     (dat_w[i]),
			.sel       (sel[i]),
			.ack       (ack[i]),
			.dat_r     (dat_r[i]),
			.inv_valid (inv_valid),
			.inv_wadr  (inv_wadr),
			.req       (ch_if[i])
		);
	end

	mpmc_mem_exec u_exec (
		.clk      (clk),
		.reset    (reset),
		.chans    (ch_if),
		.acc_done (acc_done),
		.acc_ch   (acc_ch),
		.acc_we   (acc_we),
		.acc_wadr (acc_wadr),
		.acc_rdat (acc_rdat)
	);

	mpmc_result u_result (
		.clk       (clk),
		.reset     (reset),
		.acc_done  (acc_done),
		.acc_ch    (acc_ch),
		.acc_we    (acc_we),
		.acc_wadr  (acc_wadr),
		.acc_rdat  (acc_rdat),
		.chans     (ch_if),
		.inv_valid (inv_valid),
		.inv_wadr  (inv_wadr)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

# A failed build or a simulator error exit counts as a failed run
verilator --binary --timing --assert -f build.f --top-module mpmc_tb -o mpmc_sim \
	> build.log 2>&1 && ./obj_dir/mpmc_sim > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat build.log sim.log

grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

//--- tests/mpmc_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

// =====================================================================
// Clock and reset source for the controller testbench
// =====================================================================

module mpmc_clkgen (
	output logic clk,
	output logic reset
);

	// 20 ns period
	localparam int HALF_PERIOD_NS = 10;
	localparam int RESET_CYCLES = 4;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	// Reset covers four rising edges and drops on a falling edge, clear of the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/mpmc_props.sv
`timescale 1ns/1ps
`default_nettype none

// =====================================================================
// Protocol and arbitration checks bound into the controller top level
// =====================================================================

module mpmc_props (
	input wire logic                        clk,
	input wire logic                        reset,
	input wire logic [mpmc_pkg::NUM_CH-1:0] cyc,
	input wire logic [mpmc_pkg::NUM_CH-1:0] stb,
	input wire logic [mpmc_pkg::NUM_CH-1:0] ack,
	input wire logic [mpmc_pkg::NUM_CH-1:0] wr_req,
	input wire logic [mpmc_pkg::NUM_CH-1:0] rd_req,
	input wire mpmc_pkg::ch_t               ch
);

	// The selection is registered, so it answers the requests of one cycle back
	logic [mpmc_pkg::NUM_CH-1:0] pend_d;

	always_ff @(posedge clk) begin
		if (reset)
			pend_d <= '0;
		else
			pend_d <= wr_req | rd_req;
	end

	// A slave may only acknowledge inside an active cycle
	ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
		(ack & ~(cyc & stb)) == '0)
		else $error("ack asserted while cyc or stb was low");

	// Every ack is a one cycle pulse
	ack_single: assert property (@(posedge clk) disable iff (reset)
		(ack & $past(ack)) == '0)
		else $error("ack stayed high for two cycles in a row");

	// The arbiter picks a channel that was asking, or nothing at all
	ch_requesting: assert property (@(posedge clk) disable iff (reset)
		(ch == mpmc_pkg::CH_NONE) ||
		((ch < mpmc_pkg::NUM_CH) && pend_d[ch[$clog2(mpmc_pkg::NUM_CH)-1:0]]))
		else $error("arbiter selected channel %0d with no pending request", ch);

endmodule

`default_nettype wire

//--- tests/mpmc_tb.sv
`timescale 1ns/1ps
`default_nettype none

// =====================================================================
// Testbench of the eight-channel memory controller
// =====================================================================

module mpmc_tb;

	localparam logic [31:0] SEED = 32'hff3bb6fa;
	localparam int OPS_PER_CH = 64;
	localparam int DIRECTED_OPS = 16;
	// Far above the worst wait of a request behind seven busy channels
	localparam int CYCLES_PER_ACCESS = 100;
	localparam int CLK_PERIOD_NS = 20;
	localparam int TIMEOUT_NS = (DIRECTED_OPS + mpmc_pkg::NUM_CH * OPS_PER_CH)
		* CYCLES_PER_ACCESS * CLK_PERIOD_NS;

	logic                                              clk;
	logic                                              reset;
	logic [mpmc_pkg::NUM_CH-1:0]                       cyc;
	logic [mpmc_pkg::NUM_CH-1:0]                       stb;
	logic [mpmc_pkg::NUM_CH-1:0]                       we;
	logic [mpmc_pkg::NUM_CH-1:0][mpmc_pkg::ADR_W-1:0]  adr;
	logic [mpmc_pkg::NUM_CH-1:0][mpmc_pkg::DATA_W-1:0] dat_w;
	logic [mpmc_pkg::NUM_CH-1:0][mpmc_pkg::SEL_W-1:0]  sel;
	logic [mpmc_pkg::NUM_CH-1:0]                       ack;
	logic [mpmc_pkg::NUM_CH-1:0][mpmc_pkg::DATA_W-1:0] dat_r;

	// Model memory and a flag per word once it holds a full write
	logic [mpmc_pkg::DATA_W-1:0] ref_mem [mpmc_pkg::MEM_WORDS];
	bit                          written [mpmc_pkg::MEM_WORDS];

	// Finished reads waiting for the compare process
	logic [mpmc_pkg::DATA_W-1:0] exp_q [$];
	logic [mpmc_pkg::DATA_W-1:0] act_q [$];
	int                          chan_q [$];
	int                          reads_issued;
	int                          reads_checked;

	mpmc_clkgen u_clkgen (
		.clk   (clk),
		.reset (reset)
	);

	mpmc_top mpmc_top_inst (
		.clk   (clk),
		.reset (reset),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.sel   (sel),
		.ack   (ack),
		.dat_r (dat_r)
	);

	// Arbiter internals are reached from inside the top level scope
	bind mpmc_top mpmc_props props_inst (
		.clk    (clk),
		.reset  (reset),
		.cyc    (cyc),
		.stb    (stb),
		.ack    (ack),
		.wr_req (u_exec.u_prio.wr_req),
		.rd_req (u_exec.u_prio.rd_req),
		.ch     (u_exec.u_prio.ch)
	);

	// ================================================================
	// Helpers
	// ================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Expected word after a write, each selected byte lane replaced
	function automatic logic [mpmc_pkg::DATA_W-1:0] merge_bytes(
		input logic [mpmc_pkg::DATA_W-1:0] old_word,
		input logic [mpmc_pkg::DATA_W-1:0] new_word,
		input logic [mpmc_pkg::SEL_W-1:0]  byte_sel
	);
		logic [mpmc_pkg::DATA_W-1:0] res;
		res = old_word;
		for (int b = 0; b < mpmc_pkg::SEL_W; b++) begin
			if (byte_sel[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		end
		return res;
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// One Wishbone classic access, lat counts falling edges until ack
	// The master holds stb through the edge that samples ack and drops it one cycle later
	task automatic bus_access(
		input  int                          c,
		input  logic                        wr,
		input  logic [mpmc_pkg::WADR_W-1:0] w,
		input  logic [mpmc_pkg::DATA_W-1:0] d,
		input  logic [mpmc_pkg::SEL_W-1:0]  s,
		output logic [mpmc_pkg::DATA_W-1:0] rd,
		output int                          lat
	);
		@(negedge clk);
		cyc[c]   = 1'b1;
		stb[c]   = 1'b1;
		we[c]    = wr;
		adr[c]   = {{(mpmc_pkg::ADR_W-mpmc_pkg::WADR_W-2){1'b0}}, w, 2'b00};
		dat_w[c] = d;
		sel[c]   = s;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (ack[c] !== 1'b1);
		rd = dat_r[c];
		@(negedge clk);
		cyc[c] = 1'b0;
		stb[c] = 1'b0;
		we[c]  = 1'b0;
	endtask

	task automatic write_word(
		input int                          c,
		input logic [mpmc_pkg::WADR_W-1:0] w,
		input logic [mpmc_pkg::DATA_W-1:0] d,
		input logic [mpmc_pkg::SEL_W-1:0]  s
	);
		logic [mpmc_pkg::DATA_W-1:0] rd;
		int                          lat;
		bus_access(c, 1'b1, w, d, s, rd, lat);
		ref_mem[w] = merge_bytes(ref_mem[w], d, s);
		written[w] = 1'b1;
	endtask

	// The expected word is taken from the model when the read finishes
	task automatic read_check(
		input  int                          c,
		input  logic [mpmc_pkg::WADR_W-1:0] w,
		output int                          lat
	);
		logic [mpmc_pkg::DATA_W-1:0] rd;
		bus_access(c, 1'b0, w, '0, '1, rd, lat);
		exp_q.push_back(ref_mem[w]);
		act_q.push_back(rd);
		chan_q.push_back(c);
		reads_issued++;
	endtask

	// Random traffic confined to a 32-word region per channel
	task automatic run_channel(input int c);
		logic [31:0]                 st;
		logic [31:0]                 d;
		logic [mpmc_pkg::WADR_W-1:0] w;
		int                          lat;
		st = xorshift32(SEED + 32'(c));
		for (int n = 0; n < OPS_PER_CH; n++) begin
			st = xorshift32(st);
			w  = {3'(c), st[4:0]};
			// A word gets a full write before any partial write or read
			if (!written[w] || st[5]) begin
				d = xorshift32(st ^ SEED);
				write_word(c, w, d, written[w] ? st[9:6] : 4'hf);
			end else begin
				read_check(c, w, lat);
			end
		end
	endtask

	// ================================================================
	// Compare process
	// ================================================================

	initial begin : compare
		logic [mpmc_pkg::DATA_W-1:0] e;
		logic [mpmc_pkg::DATA_W-1:0] a;
		int                          c;
		forever begin
			@(posedge clk);
			while (act_q.size() != 0) begin
				e = exp_q.pop_front();
				a = act_q.pop_front();
				c = chan_q.pop_front();
				assert (a === e)
				else stop_on_error($sformatf("mismatch dat_r[%0d] expected 0x%08h actual 0x%08h",
					c, e, a));
				reads_checked++;
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		stop_on_error($sformatf("watchdog expired after %0d ns with accesses still open",
			TIMEOUT_NS));
	end

	// ================================================================
	// Stimulus
	// ================================================================

	initial begin : stimulus
		int lat;
		cyc   = '0;
		stb   = '0;
		we    = '0;
		adr   = '0;
		dat_w = '0;
		sel   = '0;
		reads_issued  = 0;
		reads_checked = 0;
		for (int i = 0; i < mpmc_pkg::MEM_WORDS; i++) begin
			ref_mem[i] = '0;
			written[i] = 1'b0;
		end

		wait (reset === 1'b0);
		@(negedge clk);
		assert (ack === '0)
		else stop_on_error($sformatf("mismatch ack expected 0x00 actual 0x%02h", ack));

		// Write then read back on channel 0
		write_word(0, 8'h05, 32'h1234_5678, 4'hf);
		read_check(0, 8'h05, lat);

		// Partial writes merge into the stored word
		write_word(1, 8'h21, 32'ha5a5_5a5a, 4'hf);
		write_word(1, 8'h21, 32'h1122_3344, 4'b0101);
		read_check(1, 8'h21, lat);
		write_word(1, 8'h21, 32'hdead_beef, 4'b1000);
		read_check(1, 8'h21, lat);

		// The first read fills the buffer and the next two are answered from it
		write_word(2, 8'h42, 32'h0f1e_2d3c, 4'hf);
		read_check(2, 8'h42, lat);
		for (int k = 0; k < 2; k++) begin
			read_check(2, 8'h42, lat);
			assert (lat == 1)
			else stop_on_error($sformatf("read buffer hit on channel 2 took %0d cycles", lat));
		end

		// A write on channel 4 has to knock out the word buffered by channel 3
		write_word(3, 8'h63, 32'h0bad_f00d, 4'hf);
		read_check(3, 8'h63, lat);
		read_check(3, 8'h63, lat);
		write_word(4, 8'h63, 32'hcafe_0001, 4'hf);
		read_check(3, 8'h63, lat);
		assert (lat > 1)
		else stop_on_error("channel 3 answered from a buffer that should have been dropped");

		// All channels at once, many elevate cycles pass in this phase
		fork
			run_channel(0);
			run_channel(1);
			run_channel(2);
			run_channel(3);
			run_channel(4);
			run_channel(5);
			run_channel(6);
			run_channel(7);
		join

		repeat (4) @(posedge clk);
		if ((act_q.size() == 0) && (reads_checked == reads_issued)) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			stop_on_error($sformatf("only %0d of %0d reads were compared",
				reads_checked, reads_issued));
		end
	end

endmodule

`default_nettype wire
